// ==== hdl/bus_macros.svh ====
`ifndef BUS_MACROS_SVH
`define BUS_MACROS_SVH

// modulation memory geometry
`define MOD_WORDS 256
`define MOD_INDEX_W ($clog2(`MOD_WORDS) + 1)

// controller register word offsets inside sel_controller
`define ADDR_CTL_FLAG           8'h00
`define ADDR_MOD_MEM_WR_SEGMENT 8'h01
`define ADDR_MOD_REQ_RD_SEGMENT 8'h02
`define ADDR_MOD_CYCLE0         8'h03
`define ADDR_MOD_CYCLE1         8'h04

// bit positions inside the control flag word
`define CTL_FLAG_ENABLE 0

`endif

// ==== hdl/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

  // memory select, taken from the top two bits of the word address
  typedef enum logic [1:0] {
    sel_controller = 2'd0,
    sel_mod        = 2'd1
  } bus_select_t;  // 2 and 3 reserved

  typedef enum logic [1:0] {
    s_idle    = 2'd0,
    s_fetch   = 2'd1,
    s_present = 2'd2
  } sampler_state_t;

endpackage

`default_nettype wire

// ==== hdl/cpu_bus_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_bus_decoder (
  input  wire                  CPU_CKIO,
  input  wire                  rst_n,
  input  wire [15:0]           cpu_addr,
  input  wire [15:0]           cpu_data_in,
  input  wire                  cpu_cn,
  input  wire                  cpu_we0_n,
  input  wire                  cpu_rd_n,
  input  wire [15:0]           reg_rd_data,
  output logic                 wr_en,
  output bus_pkg::bus_select_t wr_select,
  output logic [13:0]          wr_addr,
  output logic [15:0]          wr_data,
  output logic [7:0]           rd_addr,
  output logic [15:0]          cpu_data_out
);
  import bus_pkg::*;

  logic [15:0] addr_q;
  logic [15:0] data_q;
  logic        cn_q;
  logic        we_q;
  logic        we_q_d;
  logic        rd_q;
  logic        we_fall;
  logic        rd_hit;

  // strobes come up inactive so no edge is seen out of reset
  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      cn_q   <= 1'b1;
      we_q   <= 1'b1;
      we_q_d <= 1'b1;
      rd_q   <= 1'b1;
    end else begin
      cn_q   <= cpu_cn;
      we_q   <= cpu_we0_n;
      we_q_d <= we_q;
      rd_q   <= cpu_rd_n;
    end
  end

  always_ff @(posedge CPU_CKIO) begin
    addr_q <= cpu_addr;
    data_q <= cpu_data_in;
  end

  assign we_fall = we_q_d & ~we_q & ~cn_q;  // one pulse per write cycle
  assign rd_hit  = ~cn_q & ~rd_q & (addr_q[15:14] == sel_controller) & (addr_q[13:8] == '0);
  assign rd_addr = addr_q[7:0];

  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      wr_en        <= 1'b0;
      cpu_data_out <= '0;
    end else begin
      wr_en        <= we_fall;
      cpu_data_out <= rd_hit ? reg_rd_data : 16'h0000;
    end
  end

  // only meaningful alongside wr_en
  always_ff @(posedge CPU_CKIO) begin
    wr_select <= bus_select_t'(addr_q[15:14]);
    wr_addr   <= addr_q[13:0];
    wr_data   <= data_q;
  end

  wr_en_single: assert property (
    @(posedge CPU_CKIO) disable iff (!rst_n)
    wr_en |=> !wr_en
  );

endmodule

`default_nettype wire

// ==== hdl/controller_regs.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "bus_macros.svh"

module controller_regs (
  input  wire                        CPU_CKIO,
  input  wire                        rst_n,
  input  wire                        wr_en,
  input  var bus_pkg::bus_select_t   wr_select,
  input  wire [13:0]                 wr_addr,
  input  wire [15:0]                 wr_data,
  input  wire [7:0]                  rd_addr,
  output logic [15:0]                reg_rd_data,
  output logic                       ctl_enable,
  output logic                       mod_wr_segment,
  output logic                       mod_req_rd_segment,
  output logic [`MOD_INDEX_W-1:0]    mod_cycle0,
  output logic [`MOD_INDEX_W-1:0]    mod_cycle1
);
  import bus_pkg::*;

  localparam int PAD_W = 16 - `MOD_INDEX_W;

  logic wr_hit;

  // upper offset bits must be clear to hit this bank
  assign wr_hit = wr_en && (wr_select == sel_controller) && (wr_addr[13:8] == '0);

  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      ctl_enable         <= 1'b0;
      mod_wr_segment     <= 1'b0;
      mod_req_rd_segment <= 1'b0;
      mod_cycle0         <= '0;
      mod_cycle1         <= '0;
    end else if (wr_hit) begin
      case (wr_addr[7:0])
        `ADDR_CTL_FLAG:           ctl_enable         <= wr_data[`CTL_FLAG_ENABLE];
        `ADDR_MOD_MEM_WR_SEGMENT: mod_wr_segment     <= wr_data[0];
        `ADDR_MOD_REQ_RD_SEGMENT: mod_req_rd_segment <= wr_data[0];
        `ADDR_MOD_CYCLE0:         mod_cycle0         <= wr_data[`MOD_INDEX_W-1:0];
        `ADDR_MOD_CYCLE1:         mod_cycle1         <= wr_data[`MOD_INDEX_W-1:0];
        default: ;  // unmapped offsets are dropped
      endcase
    end
  end

  always_comb begin
    reg_rd_data = 16'h0000;
    case (rd_addr)
      `ADDR_CTL_FLAG: begin
        reg_rd_data[`CTL_FLAG_ENABLE] = ctl_enable;
      end
      `ADDR_MOD_MEM_WR_SEGMENT: begin
        reg_rd_data[0] = mod_wr_segment;
      end
      `ADDR_MOD_REQ_RD_SEGMENT: begin
        reg_rd_data[0] = mod_req_rd_segment;
      end
      `ADDR_MOD_CYCLE0: begin
        reg_rd_data = {{PAD_W{1'b0}}, mod_cycle0};
      end
      `ADDR_MOD_CYCLE1: begin
        reg_rd_data = {{PAD_W{1'b0}}, mod_cycle1};
      end
      default: begin
        reg_rd_data = 16'h0000;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/mod_memory.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "bus_macros.svh"

module mod_memory (
  input  wire                      CPU_CKIO,
  input  wire                      wr_en,
  input  var bus_pkg::bus_select_t wr_select,
  input  wire [13:0]               wr_addr,
  input  wire [15:0]               wr_data,
  input  wire                      wr_segment,
  input  wire                      rd_segment,
  input  wire [`MOD_INDEX_W-1:0]   rd_index,
  output logic [7:0]               rd_byte
);
  import bus_pkg::*;

  localparam int WORD_AW = $clog2(`MOD_WORDS);

  logic [15:0]      mem [2*`MOD_WORDS];  // segment is the top address bit
  logic [WORD_AW:0] wr_word;
  logic [WORD_AW:0] rd_word;
  logic [15:0]      rd_word_q;
  logic             rd_hi_q;

  assign wr_word = {wr_segment, wr_addr[WORD_AW-1:0]};  // truncated to segment depth
  assign rd_word = {rd_segment, rd_index[`MOD_INDEX_W-1:1]};

  always_ff @(posedge CPU_CKIO) begin
    if (wr_en && (wr_select == sel_mod)) begin
      mem[wr_word] <= wr_data;
    end
  end

  always_ff @(posedge CPU_CKIO) begin
    rd_word_q <= mem[rd_word];
    rd_hi_q   <= rd_index[0];
  end

  // even index is the low byte
  assign rd_byte = rd_hi_q ? rd_word_q[15:8] : rd_word_q[7:0];

endmodule

`default_nettype wire

// ==== hdl/mod_sampler.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "bus_macros.svh"

module mod_sampler (
  input  wire                     CPU_CKIO,
  input  wire                     rst_n,
  input  wire                     ctl_enable,
  input  wire                     mod_req_rd_segment,
  input  wire [`MOD_INDEX_W-1:0]  mod_cycle0,
  input  wire [`MOD_INDEX_W-1:0]  mod_cycle1,
  input  wire [7:0]               rd_byte,
  input  wire                     mod_ready,
  output logic                    rd_segment,
  output logic [`MOD_INDEX_W-1:0] rd_index,
  output logic [7:0]              mod_data,
  output logic                    mod_valid,
  output logic                    mod_segment
);
  import bus_pkg::*;

  sampler_state_t          state;
  logic                    active_segment;
  logic [`MOD_INDEX_W-1:0] index;
  logic [`MOD_INDEX_W-1:0] last_index;
  logic                    fetch_wait;
  logic                    xfer;

  assign last_index  = active_segment ? mod_cycle1 : mod_cycle0;
  assign xfer        = mod_valid & mod_ready;
  assign rd_segment  = active_segment;
  assign rd_index    = index;
  assign mod_segment = active_segment;

  always_ff @(posedge CPU_CKIO) begin
    if (!rst_n) begin
      state          <= s_idle;
      active_segment <= 1'b0;
      index          <= '0;
      fetch_wait     <= 1'b0;
      mod_valid      <= 1'b0;
    end else begin
      case (state)
        s_idle: begin
          if (ctl_enable) begin
            active_segment <= mod_req_rd_segment;
            index          <= '0;
            fetch_wait     <= 1'b0;
            state          <= s_fetch;
          end
        end
        s_fetch: begin
          fetch_wait <= 1'b1;  // first cycle only addresses the memory
          if (!ctl_enable) begin
            state <= s_idle;
          end else if (fetch_wait) begin
            mod_valid <= 1'b1;
            state     <= s_present;
          end
        end
        s_present: begin
          if (xfer) begin
            mod_valid  <= 1'b0;
            fetch_wait <= 1'b0;
            if (index == last_index) begin
              index          <= '0;
              active_segment <= mod_req_rd_segment;  // segment switch only here
            end else begin
              index <= index + 1'b1;
            end
            state <= ctl_enable ? s_fetch : s_idle;
          end
        end
        default: begin
          state <= s_idle;
        end
      endcase
    end
  end

  always_ff @(posedge CPU_CKIO) begin
    if ((state == s_fetch) && fetch_wait) begin
      mod_data <= rd_byte;  // held until the transfer
    end
  end

  stall_hold: assert property (
    @(posedge CPU_CKIO) disable iff (!rst_n)
    mod_valid && !mod_ready |=> mod_valid && $stable(mod_data)
  );

  idle_no_valid: assert property (
    @(posedge CPU_CKIO) disable iff (!rst_n)
    (state == s_idle) |-> !mod_valid
  );

endmodule

`default_nettype wire

// ==== hdl/bram_subsystem_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "bus_macros.svh"

module bram_subsystem_top (
  input  wire         CPU_CKIO,
  input  wire         rst_n,
  input  wire [15:0]  cpu_addr,
  input  wire [15:0]  cpu_data_in,
  input  wire         cpu_cn,
  input  wire         cpu_we0_n,
  input  wire         cpu_rd_n,
  input  wire         mod_ready,
  output logic [15:0] cpu_data_out,
  output logic [7:0]  mod_data,
  output logic        mod_valid,
  output logic        mod_segment
);
  import bus_pkg::*;

  logic                    wr_en;
  bus_select_t             wr_select;
  logic [13:0]             wr_addr;
  logic [15:0]             wr_data;
  logic [7:0]              rd_addr;
  logic [15:0]             reg_rd_data;
  logic                    ctl_enable;
  logic                    mod_wr_segment;
  logic                    mod_req_rd_segment;
  logic [`MOD_INDEX_W-1:0] mod_cycle0;
  logic [`MOD_INDEX_W-1:0] mod_cycle1;
  logic                    rd_segment;
  logic [`MOD_INDEX_W-1:0] rd_index;
  logic [7:0]              rd_byte;

  cpu_bus_decoder cpu_bus_decoder_i (
    .CPU_CKIO     (CPU_CKIO),
    .rst_n        (rst_n),
    .cpu_addr     (cpu_addr),
    .cpu_data_in  (cpu_data_in),
    .cpu_cn       (cpu_cn),
    .cpu_we0_n    (cpu_we0_n),
    .cpu_rd_n     (cpu_rd_n),
    .reg_rd_data  (reg_rd_data),
    .wr_en        (wr_en),
    .wr_select    (wr_select),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .rd_addr      (rd_addr),
    .cpu_data_out (cpu_data_out)
  );

  controller_regs controller_regs_i (
    .CPU_CKIO           (CPU_CKIO),
    .rst_n              (rst_n),
    .wr_en              (wr_en),
    .wr_select          (wr_select),
    .wr_addr            (wr_addr),
    .wr_data            (wr_data),
    .rd_addr            (rd_addr),
    .reg_rd_data        (reg_rd_data),
    .ctl_enable         (ctl_enable),
    .mod_wr_segment     (mod_wr_segment),
    .mod_req_rd_segment (mod_req_rd_segment),
    .mod_cycle0         (mod_cycle0),
    .mod_cycle1         (mod_cycle1)
  );

  mod_memory mod_memory_i (
    .CPU_CKIO   (CPU_CKIO),
    .wr_en      (wr_en),
    .wr_select  (wr_select),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .wr_segment (mod_wr_segment),
    .rd_segment (rd_segment),
    .rd_index   (rd_index),
    .rd_byte    (rd_byte)
  );

  mod_sampler mod_sampler_i (
    .CPU_CKIO           (CPU_CKIO),
    .rst_n              (rst_n),
    .ctl_enable         (ctl_enable),
    .mod_req_rd_segment (mod_req_rd_segment),
    .mod_cycle0         (mod_cycle0),
    .mod_cycle1         (mod_cycle1),
    .rd_byte            (rd_byte),
    .mod_ready          (mod_ready),
    .rd_segment         (rd_segment),
    .rd_index           (rd_index),
    .mod_data           (mod_data),
    .mod_valid          (mod_valid),
    .mod_segment        (mod_segment)
  );

endmodule

`default_nettype wire

// ==== bench/sim_helper_bram.sv ====
`timescale 1ns/1ps
`default_nettype none

module sim_helper_bram #(
  parameter int CLK_PERIOD = 40
) (
  output logic        CPU_CKIO,
  output logic [15:0] cpu_addr,
  output logic [15:0] cpu_data_in,
  output logic        cpu_cn,
  output logic        cpu_we0_n,
  output logic        cpu_rd_n,
  input  wire  [15:0] cpu_data_out
);

  localparam int DRIVE_DLY = 1;  // ns after the rising edge

  initial begin
    CPU_CKIO    = 1'b0;
    cpu_addr    = '0;
    cpu_data_in = '0;
    cpu_cn      = 1'b1;
    cpu_we0_n   = 1'b1;
    cpu_rd_n    = 1'b1;
    forever #(CLK_PERIOD / 2) CPU_CKIO = ~CPU_CKIO;
  end

  task automatic after_edge();
    @(posedge CPU_CKIO);
    #(DRIVE_DLY);
  endtask

  // address and data stay put around the falling write strobe
  task automatic bram_write(input logic [1:0] sel, input logic [13:0] addr,
                            input logic [15:0] data);
    after_edge();
    cpu_cn      = 1'b0;
    cpu_addr    = {sel, addr};
    cpu_data_in = data;
    after_edge();
    cpu_we0_n = 1'b0;
    repeat (2) after_edge();
    cpu_we0_n = 1'b1;
    after_edge();
    cpu_cn = 1'b1;
    repeat (2) after_edge();  // decoder pipeline drains
  endtask

  task automatic bram_read(input logic [1:0] sel, input logic [13:0] addr,
                           output logic [15:0] data);
    after_edge();
    cpu_cn   = 1'b0;
    cpu_rd_n = 1'b0;
    cpu_addr = {sel, addr};
    repeat (3) after_edge();  // 2 cycles after the address is sampled
    data = cpu_data_out;
    cpu_cn   = 1'b1;
    cpu_rd_n = 1'b1;
    repeat (2) after_edge();
  endtask

endmodule

`default_nettype wire

// ==== bench/tb_bram_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "bus_macros.svh"

module tb_bram_subsystem;
  import bus_pkg::*;

  localparam int CLK_PERIOD  = 40;
  localparam int DRIVE_DLY   = 1;
  localparam int SEG_BYTES   = 10;
  localparam int FETCH_LIMIT = 16;  // cycles allowed for a byte to show up
  localparam int MAX_STALL   = 7;
  localparam int ACCESSES    = 50;  // bus accesses over all tests
  localparam int PULLS       = 80;  // stream transfers over all tests
  localparam int WATCHDOG_CYCLES =
    8 + 2 * (ACCESSES * 12 + PULLS * (FETCH_LIMIT + MAX_STALL + 3));

  wire        CPU_CKIO;
  wire [15:0] cpu_addr;
  wire [15:0] cpu_data_in;
  wire        cpu_cn;
  wire        cpu_we0_n;
  wire        cpu_rd_n;
  wire [15:0] cpu_data_out;
  wire [7:0]  mod_data;
  wire        mod_valid;
  wire        mod_segment;
  logic       rst_n;
  logic       mod_ready;

  int         errors = 0;
  int         seed = 41;
  logic [7:0] seg_bytes [2][SEG_BYTES];
  int         last_idx [2];
  int         exp_idx;
  logic       exp_seg;
  logic       req_seg;

  sim_helper_bram #(.CLK_PERIOD(CLK_PERIOD)) bus_drv (
    .CPU_CKIO     (CPU_CKIO),
    .cpu_addr     (cpu_addr),
    .cpu_data_in  (cpu_data_in),
    .cpu_cn       (cpu_cn),
    .cpu_we0_n    (cpu_we0_n),
    .cpu_rd_n     (cpu_rd_n),
    .cpu_data_out (cpu_data_out)
  );

  bram_subsystem_top bram_subsystem_top_i (
    .CPU_CKIO     (CPU_CKIO),
    .rst_n        (rst_n),
    .cpu_addr     (cpu_addr),
    .cpu_data_in  (cpu_data_in),
    .cpu_cn       (cpu_cn),
    .cpu_we0_n    (cpu_we0_n),
    .cpu_rd_n     (cpu_rd_n),
    .mod_ready    (mod_ready),
    .cpu_data_out (cpu_data_out),
    .mod_data     (mod_data),
    .mod_valid    (mod_valid),
    .mod_segment  (mod_segment)
  );

  task automatic write_reg(input logic [7:0] offset, input logic [15:0] data);
    bus_drv.bram_write(sel_controller, 14'(offset), data);
  endtask

  task automatic expect_reg(input logic [7:0] offset, input logic [15:0] exp);
    logic [15:0] data;
    bus_drv.bram_read(sel_controller, 14'(offset), data);
    assert (data === exp) else begin
      errors++;
      $display("Fail at %0t: register 0x%02h read 0x%04h, expected 0x%04h",
               $time, offset, data, exp);
    end
  endtask

  task automatic load_segment(input logic seg);
    write_reg(`ADDR_MOD_MEM_WR_SEGMENT, {15'd0, seg});
    for (int w = 0; w < SEG_BYTES / 2; w++) begin
      bus_drv.bram_write(sel_mod, 14'(w), {seg_bytes[seg][2*w+1], seg_bytes[seg][2*w]});
    end
  endtask

  // waits for a byte, stalls it, then accepts it and steps the index model
  task automatic take_and_check(input int stall);
    int         waited;
    logic [7:0] held;
    waited = 0;
    @(negedge CPU_CKIO);
    while (!mod_valid && waited < FETCH_LIMIT) begin
      @(negedge CPU_CKIO);
      waited++;
    end
    assert (mod_valid) else begin
      errors++;
      $display("no modulation byte offered within %0d cycles at %0t", FETCH_LIMIT, $time);
    end
    held = mod_data;
    assert (held === seg_bytes[exp_seg][exp_idx] && mod_segment === exp_seg) else begin
      errors++;
      $display("Fail at %0t: byte 0x%02h seg %0b, expected 0x%02h seg %0b index %0d",
               $time, held, mod_segment, seg_bytes[exp_seg][exp_idx], exp_seg, exp_idx);
    end
    repeat (stall) begin
      @(negedge CPU_CKIO);
      assert (mod_valid && mod_data === held) else begin
        errors++;
        $display("Fail at %0t: stalled byte became 0x%02h valid %0b, held 0x%02h",
                 $time, mod_data, mod_valid, held);
      end
    end
    @(posedge CPU_CKIO);
    #(DRIVE_DLY) mod_ready = 1'b1;
    @(posedge CPU_CKIO);  // transfer edge
    #(DRIVE_DLY) mod_ready = 1'b0;
    if (exp_idx == last_idx[exp_seg]) begin
      exp_idx = 0;
      exp_seg = req_seg;  // wrap picks up the requested segment
    end else begin
      exp_idx++;
    end
  endtask

  task automatic test_after_reset();
    assert (mod_valid === 1'b0 && cpu_data_out === 16'h0000) else begin
      errors++;
      $display("Fail at %0t: after reset mod_valid %0b cpu_data_out 0x%04h",
               $time, mod_valid, cpu_data_out);
    end
    for (int a = 0; a <= 5; a++) begin
      expect_reg(8'(a), 16'h0000);
    end
  endtask

  task automatic test_reg_access();
    write_reg(`ADDR_CTL_FLAG, 16'hFFFE);  // enable bit stays clear
    expect_reg(`ADDR_CTL_FLAG, 16'h0000);
    write_reg(`ADDR_MOD_MEM_WR_SEGMENT, 16'hFFFF);
    expect_reg(`ADDR_MOD_MEM_WR_SEGMENT, 16'h0001);
    write_reg(`ADDR_MOD_REQ_RD_SEGMENT, 16'h8003);
    expect_reg(`ADDR_MOD_REQ_RD_SEGMENT, 16'h0001);
    write_reg(`ADDR_MOD_CYCLE0, 16'hFFFF);
    expect_reg(`ADDR_MOD_CYCLE0, 16'h01FF);
    write_reg(`ADDR_MOD_CYCLE1, 16'h1234);
    expect_reg(`ADDR_MOD_CYCLE1, 16'h0034);
    write_reg(8'h05, 16'hBEEF);
    expect_reg(8'h05, 16'h0000);
    bus_drv.bram_write(2'd2, 14'(`ADDR_MOD_CYCLE0), 16'h0055);  // reserved select
    expect_reg(`ADDR_MOD_CYCLE0, 16'h01FF);
    write_reg(`ADDR_MOD_MEM_WR_SEGMENT, 16'h0000);
    write_reg(`ADDR_MOD_REQ_RD_SEGMENT, 16'h0000);
  endtask

  task automatic test_streaming();
    for (int i = 0; i < SEG_BYTES; i++) begin
      seg_bytes[0][i] = 8'($random(seed));
    end
    load_segment(1'b0);
    write_reg(`ADDR_MOD_CYCLE0, 16'd9);
    last_idx[0] = 9;
    req_seg = 1'b0;
    write_reg(`ADDR_CTL_FLAG, 16'h0001);
    expect_reg(`ADDR_CTL_FLAG, 16'h0001);
    exp_idx = 0;
    exp_seg = 1'b0;
    repeat (25) take_and_check(0);
  endtask

  task automatic test_back_pressure();
    repeat (25) take_and_check($unsigned($random(seed)) % (MAX_STALL + 1));
  endtask

  task automatic test_segment_switch();
    for (int i = 0; i < SEG_BYTES; i++) begin
      seg_bytes[1][i] = 8'($random(seed));
      if (seg_bytes[1][i] == seg_bytes[0][i]) begin
        seg_bytes[1][i] = ~seg_bytes[1][i];
      end
    end
    load_segment(1'b1);
    write_reg(`ADDR_MOD_CYCLE1, 16'd7);
    last_idx[1] = 7;
    while (exp_idx != 4) take_and_check(0);
    write_reg(`ADDR_MOD_REQ_RD_SEGMENT, 16'h0001);  // mid cycle
    req_seg = 1'b1;
    while (exp_seg == 1'b0) take_and_check(0);
    repeat (10) take_and_check(0);
  endtask

  task automatic test_disable();
    write_reg(`ADDR_CTL_FLAG, 16'h0000);
    @(negedge CPU_CKIO);
    if (mod_valid) begin
      take_and_check(0);  // pending byte still goes out
    end
    repeat (20) begin
      @(negedge CPU_CKIO);
      assert (!mod_valid) else begin
        errors++;
        $display("Fail at %0t: mod_valid high after the sampler was disabled", $time);
      end
    end
    expect_reg(`ADDR_CTL_FLAG, 16'h0000);
  endtask

  initial begin
    rst_n       = 1'b0;
    mod_ready   = 1'b0;
    exp_idx     = 0;
    exp_seg     = 1'b0;
    req_seg     = 1'b0;
    last_idx[0] = 0;
    last_idx[1] = 0;
    repeat (8) @(posedge CPU_CKIO);
    #(DRIVE_DLY) rst_n = 1'b1;
    test_after_reset();
    test_reg_access();
    test_streaming();
    test_back_pressure();
    test_segment_switch();
    test_disable();
    $display("%0d errors", errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+hdl
hdl/bus_pkg.sv
hdl/cpu_bus_decoder.sv
hdl/controller_regs.sv
hdl/mod_memory.sv
hdl/mod_sampler.sv
hdl/bram_subsystem_top.sv
bench/sim_helper_bram.sv
bench/tb_bram_subsystem.sv

// ==== Bender.yml ====
package:
  name: bram_subsystem

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/bus_pkg.sv
      - hdl/cpu_bus_decoder.sv
      - hdl/controller_regs.sv
      - hdl/mod_memory.sv
      - hdl/mod_sampler.sv
      - hdl/bram_subsystem_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - bench/sim_helper_bram.sv
      - bench/tb_bram_subsystem.sv
